/* src/hdu_pkg.sv */
// hazard detection unit shared types
package hdu_pkg;

    // architectural register file
    localparam int REG_ADDR_W = 5;

    // pending-write table geometry
    localparam int NUM_SLOTS = 8;  // slot 0 reserved, means no id
    localparam int ID_W      = 3;  // completion id width

    // pair issue needs two free slots out of 1..7
    localparam int MAX_USED_PAIR = NUM_SLOTS - 3;

    // id shown for an instruction that did not issue
    localparam logic [ID_W-1:0] ID_NONE = '0;

    // register zero, never a hazard and never recorded
    localparam logic [REG_ADDR_W-1:0] REG_ZERO = '0;

    // one decoded instruction from the decode stage
    typedef struct packed {
        logic                  valid;      // slot holds a real instruction
        logic [REG_ADDR_W-1:0] rd;         // destination
        logic [REG_ADDR_W-1:0] rs1;        // source 1
        logic [REG_ADDR_W-1:0] rs2;        // source 2
        logic                  rd_we;      // writes rd
        logic                  is_branch;  // conditional branch
        logic                  is_jump;    // jal / jalr / system jump
    } inst_info_t;

    // release strobe from a write-back unit
    typedef struct packed {
        logic            valid;  // single-cycle strobe
        logic [ID_W-1:0] id;     // slot being released
    } commit_t;

    // table match result per slot position
    typedef struct packed {
        logic a_hit;  // A touches an outstanding rd
        logic b_hit;  // B touches an outstanding rd
    } ext_hazard_t;

    // issue selection, bit 0 = A, bit 1 = B
    typedef enum logic [1:0] {
        ISSUE_NONE = 2'b00,
        ISSUE_A    = 2'b01,
        ISSUE_B    = 2'b10,
        ISSUE_BOTH = 2'b11
    } issue_sel_e;

    // true when inst reads or writes the given register
    // x0 and non-writing destinations filtered out
    function automatic logic touches_reg(inst_info_t inst, logic [REG_ADDR_W-1:0] r);
        logic src_hit;
        logic dst_hit;
        src_hit = ((inst.rs1 != REG_ZERO) && (inst.rs1 == r)) ||
                  ((inst.rs2 != REG_ZERO) && (inst.rs2 == r));
        dst_hit = inst.rd_we && (inst.rd != REG_ZERO) && (inst.rd == r);
        return inst.valid && (src_hit || dst_hit);
    endfunction

endpackage

/* src/pending_write_table.sv */
// pending register write table
`timescale 1ns/1ps

module pending_write_table import hdu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  inst_info_t      inst_a_i,     // older slot
    input  inst_info_t      inst_b_i,     // younger slot
    input  commit_t         commit0_i,    // write-back release 0
    input  commit_t         commit1_i,    // write-back release 1
    input  issue_sel_e      issue_i,      // this cycle's issue decision
    input  logic [ID_W-1:0] id_a_i,       // id handed to A
    input  logic [ID_W-1:0] id_b_i,       // id handed to B
    output ext_hazard_t     ext_haz_o,
    output logic [ID_W-1:0] free_id_a_o,  // lowest free slot
    output logic [ID_W-1:0] free_id_b_o,  // next free above it, wrapping
    output logic            two_free_o,   // room for a full pair
    output logic            busy_o        // any write outstanding
);

    logic [NUM_SLOTS-1:0]  slot_valid;                 // bit 0 never set
    logic [REG_ADDR_W-1:0] slot_rd [1:NUM_SLOTS-1];    // pending destinations

    logic [NUM_SLOTS-1:0]  release_mask;  // slots freed this cycle
    logic [NUM_SLOTS-1:0]  set_mask;      // slots claimed this cycle
    logic [NUM_SLOTS-1:0]  live;          // still blocking this cycle
    logic [ID_W:0]         used_cnt;      // occupied among 1..7
    logic                  rec_a;
    logic                  rec_b;

    // step forward from base within 1..NUM_SLOTS-1, wrapping past the top
    function automatic logic [ID_W-1:0] wrap_slot(logic [ID_W-1:0] base, int step);
        int raw;
        raw = int'(base) + step;
        if (raw > NUM_SLOTS - 1) begin
            raw = raw - (NUM_SLOTS - 1);
        end
        return ID_W'(raw);
    endfunction

    // commit bypass, a released slot no longer blocks
    always_comb begin
        release_mask = '0;
        if (commit0_i.valid) release_mask[commit0_i.id] = 1'b1;
        if (commit1_i.valid) release_mask[commit1_i.id] = 1'b1;
    end

    assign live = slot_valid & ~release_mask;

    // match both instructions against every live slot
    always_comb begin
        ext_haz_o = '0;
        for (int i = 1; i < NUM_SLOTS; i++) begin
            if (live[i]) begin
                ext_haz_o.a_hit = ext_haz_o.a_hit | touches_reg(inst_a_i, slot_rd[i]);
                ext_haz_o.b_hit = ext_haz_o.b_hit | touches_reg(inst_b_i, slot_rd[i]);
            end
        end
    end

    // allocation looks at registered state only
    // descending scan so the lowest free slot wins
    always_comb begin
        free_id_a_o = ID_NONE;
        for (int i = NUM_SLOTS - 1; i >= 1; i--) begin
            if (!slot_valid[i]) free_id_a_o = ID_W'(i);
        end
    end

    // nearest free slot after free_id_a, same trick
    always_comb begin
        free_id_b_o = ID_NONE;
        for (int k = NUM_SLOTS - 2; k >= 1; k--) begin
            if (!slot_valid[wrap_slot(free_id_a_o, k)]) begin
                free_id_b_o = wrap_slot(free_id_a_o, k);
            end
        end
    end

    // occupancy of the usable slots
    always_comb begin
        used_cnt = '0;
        for (int i = 1; i < NUM_SLOTS; i++) begin
            used_cnt = used_cnt + {{ID_W{1'b0}}, slot_valid[i]};
        end
    end

    assign two_free_o = (used_cnt <= MAX_USED_PAIR);

    // only issued writers to a real register take a slot
    assign rec_a = issue_i[0] && inst_a_i.valid && inst_a_i.rd_we &&
                   (inst_a_i.rd != REG_ZERO) && (id_a_i != ID_NONE);
    assign rec_b = issue_i[1] && inst_b_i.valid && inst_b_i.rd_we &&
                   (inst_b_i.rd != REG_ZERO) && (id_b_i != ID_NONE);

    always_comb begin
        set_mask = '0;
        if (rec_a) set_mask[id_a_i] = 1'b1;
        if (rec_b) set_mask[id_b_i] = 1'b1;
    end

    // release then claim, claims only hit free slots
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid <= '0;
        end else begin
            slot_valid <= (slot_valid & ~release_mask) | set_mask;
        end
    end

    // destination payload
    always_ff @(posedge clk) begin
        if (rec_a) slot_rd[id_a_i] <= inst_a_i.rd;
        if (rec_b) slot_rd[id_b_i] <= inst_b_i.rd;
    end

    assign busy_o = |slot_valid;  // atomic lock

endmodule

/* src/pair_dep_check.sv */
// same-cycle pair dependency check
`timescale 1ns/1ps

module pair_dep_check import hdu_pkg::*; (
    input  inst_info_t inst_a_i,   // older, issues first
    input  inst_info_t inst_b_i,   // younger
    output logic       pair_haz_o  // B must wait for A
);

    logic a_writes;  // A produces a real register
    logic b_live;
    logic raw_rs1;   // B rs1 reads A rd
    logic raw_rs2;   // B rs2 reads A rd
    logic raw;
    logic waw;       // both write the same rd

    // x0 writes are discarded, so A only matters with a real rd
    assign a_writes = inst_a_i.valid && inst_a_i.rd_we &&
                      (inst_a_i.rd != REG_ZERO);

    assign b_live = inst_b_i.valid;

    // read after write
    assign raw_rs1 = (inst_b_i.rs1 != REG_ZERO) &&
                     (inst_b_i.rs1 == inst_a_i.rd);
    assign raw_rs2 = (inst_b_i.rs2 != REG_ZERO) &&
                     (inst_b_i.rs2 == inst_a_i.rd);
    assign raw     = raw_rs1 || raw_rs2;

    // write after write, B would retire its value under A's
    assign waw = inst_b_i.rd_we && (inst_b_i.rd == inst_a_i.rd);

    // a_writes already excludes rd == 0 on both compares
    assign pair_haz_o = a_writes && b_live && (raw || waw);

endmodule

/* src/issue_arbiter.sv */
// dual issue arbiter
`timescale 1ns/1ps

module issue_arbiter import hdu_pkg::*; (
    input  inst_info_t      inst_a_i,
    input  inst_info_t      inst_b_i,
    input  ext_hazard_t     ext_haz_i,    // against outstanding writes
    input  logic            pair_haz_i,   // B depends on A
    input  logic            two_free_i,   // table can take a pair
    input  logic            irq_hold_i,   // interrupt entry pending
    input  logic [ID_W-1:0] free_id_a_i,
    input  logic [ID_W-1:0] free_id_b_i,
    output issue_sel_e      issue_o,
    output logic [ID_W-1:0] id_a_o,
    output logic [ID_W-1:0] id_b_o
);

    logic       a_ctrl;   // A redirects fetch
    logic       b_clear;  // B free of table and of A
    issue_sel_e sel;

    // branches and jumps always go alone
    assign a_ctrl = inst_a_i.is_branch || inst_a_i.is_jump;

    assign b_clear = !ext_haz_i.b_hit && !pair_haz_i;

    // priority chain, first match wins
    always_comb begin
        sel = ISSUE_NONE;
        if (!two_free_i || irq_hold_i) begin
            sel = ISSUE_NONE;                 // stall, upstream holds the pair
        end else if (ext_haz_i.a_hit) begin
            if (a_ctrl) begin
                sel = ISSUE_NONE;             // control flow waits for its operands
            end else if (b_clear) begin
                sel = ISSUE_B;                // B slips past the blocked A
            end else begin
                sel = ISSUE_NONE;
            end
        end else if (a_ctrl) begin
            sel = ISSUE_A;                    // serialize after branch/jump
        end else if (!b_clear) begin
            sel = ISSUE_A;
        end else begin
            sel = ISSUE_BOTH;
        end
    end

    assign issue_o = sel;

    // bit 0 = A, bit 1 = B
    // an invalid slot is not really issued, so it shows no id either
    always_comb begin
        id_a_o = ID_NONE;
        id_b_o = ID_NONE;
        if (sel[0] && inst_a_i.valid) begin
            id_a_o = free_id_a_i;
        end
        if (sel[1] && inst_b_i.valid) begin
            id_b_o = sel[0] ? free_id_b_i : free_id_a_i;  // B alone takes the lowest
        end
    end

endmodule

/* src/dual_issue_hdu.sv */
// dual issue hazard detection unit
`timescale 1ns/1ps

module dual_issue_hdu import hdu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  inst_info_t      inst_a_i,    // older instruction
    input  inst_info_t      inst_b_i,    // younger instruction
    input  commit_t         commit0_i,   // from write-back
    input  commit_t         commit1_i,
    input  logic            irq_hold_i,
    output issue_sel_e      issue_o,
    output logic [ID_W-1:0] id_a_o,
    output logic [ID_W-1:0] id_b_o,
    output logic            busy_o       // outstanding writes exist
);

    ext_hazard_t     ext_haz;
    logic [ID_W-1:0] free_id_a;
    logic [ID_W-1:0] free_id_b;
    logic            two_free;
    logic            pair_haz;

    // outputs here never depend on issue/ids, no loop through the feedback
    pending_write_table u_pending_write_table (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_a_i    (inst_a_i),
        .inst_b_i    (inst_b_i),
        .commit0_i   (commit0_i),
        .commit1_i   (commit1_i),
        .issue_i     (issue_o),     // recorded at next edge
        .id_a_i      (id_a_o),
        .id_b_i      (id_b_o),
        .ext_haz_o   (ext_haz),
        .free_id_a_o (free_id_a),
        .free_id_b_o (free_id_b),
        .two_free_o  (two_free),
        .busy_o      (busy_o)
    );

    pair_dep_check u_pair_dep_check (
        .inst_a_i   (inst_a_i),
        .inst_b_i   (inst_b_i),
        .pair_haz_o (pair_haz)
    );

    issue_arbiter u_issue_arbiter (
        .inst_a_i    (inst_a_i),
        .inst_b_i    (inst_b_i),
        .ext_haz_i   (ext_haz),
        .pair_haz_i  (pair_haz),
        .two_free_i  (two_free),
        .irq_hold_i  (irq_hold_i),
        .free_id_a_i (free_id_a),
        .free_id_b_i (free_id_b),
        .issue_o     (issue_o),
        .id_a_o      (id_a_o),
        .id_b_o      (id_b_o)
    );

endmodule

/* dv/hdu_checker.sv */
// hazard unit response checker
`timescale 1ns/1ps

module hdu_checker import hdu_pkg::*; (
    input  logic            clk,
    input  logic            row_valid_i,   // a test row is on the inputs
    input  logic [159:0]    test_name_i,
    input  issue_sel_e      exp_issue_i,
    input  logic [ID_W-1:0] exp_id_a_i,
    input  logic [ID_W-1:0] exp_id_b_i,
    input  logic            exp_busy_i,    // value after the row's edge
    input  issue_sel_e      issue_i,       // DUT outputs
    input  logic [ID_W-1:0] id_a_i,
    input  logic [ID_W-1:0] id_b_i,
    input  logic            busy_i,
    input  logic            done_i,        // stimulus finished
    output int              pass_cnt_o,
    output int              fail_cnt_o
);

    localparam int SETTLE_NS = 8;  // 2 ns ahead of the following edge

    int              n_pass   = 0;
    int              n_fail   = 0;
    logic            checking = 1'b0;  // row latched in this cycle
    logic [159:0]    name_q;
    issue_sel_e      exp_issue_q;
    issue_sel_e      act_issue_q;
    logic [ID_W-1:0] exp_id_a_q;
    logic [ID_W-1:0] exp_id_b_q;
    logic [ID_W-1:0] act_id_a_q;
    logic [ID_W-1:0] act_id_b_q;
    logic            exp_busy_q;
    logic            act_busy_q;
    logic            match;
    string           exp_txt;
    string           act_txt;

    assign pass_cnt_o = n_pass;
    assign fail_cnt_o = n_fail;

    always begin
        @(negedge clk);
        #SETTLE_NS;                      // comb outputs settled, before rising edge
        checking = row_valid_i;
        if (checking) begin
            name_q      = test_name_i;
            exp_issue_q = exp_issue_i;
            exp_id_a_q  = exp_id_a_i;
            exp_id_b_q  = exp_id_b_i;
            exp_busy_q  = exp_busy_i;
            act_issue_q = issue_i;
            act_id_a_q  = id_a_i;
            act_id_b_q  = id_b_i;
        end
        @(posedge clk);
        #SETTLE_NS;                      // busy registered, before next falling edge
        if (checking) begin
            act_busy_q = busy_i;
            match = (act_issue_q === exp_issue_q) && (act_id_a_q === exp_id_a_q) &&
                    (act_id_b_q === exp_id_b_q) && (act_busy_q === exp_busy_q);
            if (match) begin
                n_pass++;
                $display("PASS   %0s", name_q);
            end else begin
                n_fail++;
                exp_txt = $sformatf("issue=%s id_a=%0d id_b=%0d busy=%b",
                                    exp_issue_q.name(), exp_id_a_q, exp_id_b_q, exp_busy_q);
                act_txt = $sformatf("issue=%s id_a=%0d id_b=%0d busy=%b",
                                    act_issue_q.name(), act_id_a_q, act_id_b_q, act_busy_q);
                $display("FAILED %0s: expected %0s, actual %0s", name_q, exp_txt, act_txt);
            end
        end
    end

    // closing summary
    always @(posedge done_i) begin
        $display("tests run: %0d, passed: %0d, failed: %0d",
                 n_pass + n_fail, n_pass, n_fail);
    end

endmodule

/* dv/hdu_tb.sv */
// hazard unit testbench
`timescale 1ns/1ps

module hdu_tb import hdu_pkg::*; ();

    localparam int          CLK_HALF   = 10;
    localparam int          CLK_PERIOD = 2 * CLK_HALF;
    localparam int          RST_CYCLES = 4;
    localparam int          NUM_ROWS   = 22;
    localparam int          MARGIN_NS  = 20 * CLK_PERIOD;  // reset plus drain
    localparam int          TIMEOUT_NS = NUM_ROWS * CLK_PERIOD + MARGIN_NS;
    localparam logic [31:0] SEED       = 32'h76de164b;

    // one test: stimulus and expected response
    typedef struct packed {
        logic [159:0]    name;
        inst_info_t      inst_a;
        inst_info_t      inst_b;
        commit_t         commit0;
        commit_t         commit1;
        logic            irq_hold;
        issue_sel_e      exp_issue;
        logic [ID_W-1:0] exp_id_a;
        logic [ID_W-1:0] exp_id_b;
        logic            exp_busy;   // after the row's rising edge
    } test_row_t;

    logic            clk;
    logic            rst_n;
    inst_info_t      inst_a;
    inst_info_t      inst_b;
    commit_t         commit0;
    commit_t         commit1;
    logic            irq_hold;
    issue_sel_e      issue;
    logic [ID_W-1:0] id_a;
    logic [ID_W-1:0] id_b;
    logic            busy;

    logic            row_valid;
    logic [159:0]    test_name;
    issue_sel_e      exp_issue;
    logic [ID_W-1:0] exp_id_a;
    logic [ID_W-1:0] exp_id_b;
    logic            exp_busy;
    logic            done;
    int              pass_cnt;
    int              fail_cnt;

    test_row_t       rows [0:NUM_ROWS-1];
    int              n_rows;
    integer          seed;

    dual_issue_hdu u_dual_issue_hdu (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_a_i   (inst_a),
        .inst_b_i   (inst_b),
        .commit0_i  (commit0),
        .commit1_i  (commit1),
        .irq_hold_i (irq_hold),
        .issue_o    (issue),
        .id_a_o     (id_a),
        .id_b_o     (id_b),
        .busy_o     (busy)
    );

    hdu_checker u_hdu_checker (
        .clk         (clk),
        .row_valid_i (row_valid),
        .test_name_i (test_name),
        .exp_issue_i (exp_issue),
        .exp_id_a_i  (exp_id_a),
        .exp_id_b_i  (exp_id_b),
        .exp_busy_i  (exp_busy),
        .issue_i     (issue),
        .id_a_i      (id_a),
        .id_b_i      (id_b),
        .busy_i      (busy),
        .done_i      (done),
        .pass_cnt_o  (pass_cnt),
        .fail_cnt_o  (fail_cnt)
    );

    always #CLK_HALF clk = ~clk;

    // random rd for instructions that do not write, never looked at
    function automatic logic [REG_ADDR_W-1:0] filler_reg();
        integer r;
        r = $random(seed);
        return r[REG_ADDR_W-1:0];
    endfunction

    function automatic inst_info_t alu_op(int rd, int rs1, int rs2);
        inst_info_t i;
        i = '0;
        i.valid = 1'b1;
        i.rd    = REG_ADDR_W'(rd);
        i.rs1   = REG_ADDR_W'(rs1);
        i.rs2   = REG_ADDR_W'(rs2);
        i.rd_we = 1'b1;
        return i;
    endfunction

    function automatic inst_info_t branch_op(int rs1, int rs2);
        inst_info_t i;
        i = alu_op(0, rs1, rs2);
        i.rd        = filler_reg();
        i.rd_we     = 1'b0;   // compare only
        i.is_branch = 1'b1;
        return i;
    endfunction

    function automatic inst_info_t jump_op(int rd, int rs1);
        inst_info_t i;
        i = alu_op(rd, rs1, 0);  // link register write
        i.is_jump = 1'b1;
        return i;
    endfunction

    function automatic inst_info_t no_inst();
        inst_info_t i;
        i = '0;
        i.rd = filler_reg();
        return i;
    endfunction

    function automatic commit_t commit_of(int id);
        commit_t c;
        c.valid = 1'b1;
        c.id    = ID_W'(id);
        return c;
    endfunction

    function automatic commit_t no_commit();
        return '0;
    endfunction

    task automatic add_row(input logic [159:0] name, input inst_info_t a, input inst_info_t b,
                           input commit_t c0, input commit_t c1, input int irq,
                           input issue_sel_e sel, input int ida, input int idb, input int bsy);
        test_row_t r;
        r.name      = name;
        r.inst_a    = a;
        r.inst_b    = b;
        r.commit0   = c0;
        r.commit1   = c1;
        r.irq_hold  = (irq != 0);
        r.exp_issue = sel;
        r.exp_id_a  = ID_W'(ida);
        r.exp_id_b  = ID_W'(idb);
        r.exp_busy  = (bsy != 0);
        rows[n_rows] = r;
        n_rows++;
    endtask

    // slot contents after each row noted at the end of the line
    task automatic build_table();
        add_row("reset_idle", no_inst(), no_inst(),
                no_commit(), no_commit(), 0, ISSUE_BOTH, 0, 0, 0);
        add_row("indep_pair", alu_op(5, 1, 2), alu_op(6, 3, 4),
                no_commit(), no_commit(), 0, ISSUE_BOTH, 1, 2, 1);  // 1:x5 2:x6
        add_row("tbl_a_raw", alu_op(7, 5, 0), alu_op(8, 9, 10),
                no_commit(), no_commit(), 0, ISSUE_B, 0, 3, 1);     // B lands in 3
        add_row("tbl_b_block", alu_op(11, 1, 2), alu_op(12, 8, 0),
                no_commit(), no_commit(), 0, ISSUE_A, 4, 0, 1);     // 4:x11
        add_row("pair_raw", alu_op(13, 1, 2), alu_op(14, 13, 3),
                no_commit(), no_commit(), 0, ISSUE_A, 5, 0, 1);     // 5:x13, five used
        add_row("pair_waw", alu_op(15, 1, 2), alu_op(15, 3, 4),
                commit_of(1), commit_of(2), 0, ISSUE_A, 6, 0, 1);   // 3 4 5 6 left
        add_row("x0_both", alu_op(0, 0, 0), alu_op(0, 0, 0),
                no_commit(), no_commit(), 0, ISSUE_BOTH, 1, 2, 1);  // nothing recorded
        add_row("branch_clear", branch_op(1, 2), alu_op(16, 3, 17),
                no_commit(), no_commit(), 0, ISSUE_A, 1, 0, 1);
        add_row("jump_tbl_haz", jump_op(1, 11), alu_op(18, 19, 20),
                no_commit(), no_commit(), 0, ISSUE_NONE, 0, 0, 1);
        add_row("irq_hold", alu_op(21, 1, 2), alu_op(22, 3, 4),
                no_commit(), no_commit(), 1, ISSUE_NONE, 0, 0, 1);
        add_row("commit_bypass", alu_op(23, 13, 0), alu_op(24, 25, 26),
                commit_of(5), no_commit(), 0, ISSUE_BOTH, 1, 2, 1); // 1 2 3 4 6
        add_row("commit_pair", no_inst(), no_inst(),
                commit_of(3), commit_of(4), 0, ISSUE_BOTH, 0, 0, 1);
        add_row("reuse_lowest", alu_op(27, 1, 2), alu_op(28, 3, 4),
                no_commit(), no_commit(), 0, ISSUE_BOTH, 3, 4, 1);
        add_row("fill_sixth", alu_op(29, 1, 2), no_inst(),
                no_commit(), no_commit(), 0, ISSUE_BOTH, 5, 0, 1);  // six used
        add_row("capacity_stall", alu_op(30, 1, 2), alu_op(31, 3, 4),
                no_commit(), no_commit(), 0, ISSUE_NONE, 0, 0, 1);
        add_row("stall_with_commit", alu_op(30, 1, 2), alu_op(31, 3, 4),
                commit_of(6), no_commit(), 0, ISSUE_NONE, 0, 0, 1);
        add_row("capacity_recover", alu_op(30, 1, 2), alu_op(31, 3, 4),
                no_commit(), no_commit(), 0, ISSUE_BOTH, 6, 7, 1);  // table full
        add_row("drain_full", no_inst(), no_inst(),
                commit_of(1), commit_of(2), 0, ISSUE_NONE, 0, 0, 1);
        add_row("drain_3_4", no_inst(), no_inst(),
                commit_of(3), commit_of(4), 0, ISSUE_BOTH, 0, 0, 1);
        add_row("drain_5_6", no_inst(), no_inst(),
                commit_of(5), commit_of(6), 0, ISSUE_BOTH, 0, 0, 1);
        add_row("drain_last", no_inst(), no_inst(),
                commit_of(7), no_commit(), 0, ISSUE_BOTH, 0, 0, 0);
        add_row("idle_after", no_inst(), no_inst(),
                no_commit(), no_commit(), 0, ISSUE_BOTH, 0, 0, 0);
    endtask

    task automatic apply_row(input test_row_t r);
        inst_a    = r.inst_a;
        inst_b    = r.inst_b;
        commit0   = r.commit0;
        commit1   = r.commit1;
        irq_hold  = r.irq_hold;
        test_name = r.name;
        exp_issue = r.exp_issue;
        exp_id_a  = r.exp_id_a;
        exp_id_b  = r.exp_id_b;
        exp_busy  = r.exp_busy;
        row_valid = 1'b1;
    endtask

    initial begin
        seed      = SEED;
        n_rows    = 0;
        clk       = 1'b0;
        rst_n     = 1'b0;
        inst_a    = '0;
        inst_b    = '0;
        commit0   = '0;
        commit1   = '0;
        irq_hold  = 1'b0;
        row_valid = 1'b0;
        test_name = '0;
        exp_issue = ISSUE_NONE;
        exp_id_a  = '0;
        exp_id_b  = '0;
        exp_busy  = 1'b0;
        done      = 1'b0;
        build_table();
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            apply_row(rows[i]);              // one row per cycle
            @(negedge clk);
        end
        apply_row('0);
        row_valid = 1'b0;
        done = 1'b1;
        #1;                                  // let the summary print first
        if (fail_cnt == 0 && pass_cnt == n_rows) begin
            $display("ALL TESTS PASSED");
        end else begin
            if (pass_cnt + fail_cnt != n_rows) begin
                $display("error: only %0d of %0d tests were checked",
                         pass_cnt + fail_cnt, n_rows);
            end
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #TIMEOUT_NS;
        $display("error: simulation timed out after %0d ns", TIMEOUT_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* build.f */
src/hdu_pkg.sv
src/pending_write_table.sv
src/pair_dep_check.sv
src/issue_arbiter.sv
src/dual_issue_hdu.sv
dv/hdu_checker.sv
dv/hdu_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the hazard unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module hdu_tb -o hdu_sim \
    || { echo "build failed"; exit 1; }

out=$(./obj_dir/hdu_sim)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -q "ALL TESTS PASSED" \
    && echo "simulation result: pass" \
    || { echo "simulation result: fail"; exit 1; }

exit 0
